// File: common/ecc_pkg.sv
package ecc_pkg;

    localparam int WORD_W = 32;                 // field element width
    localparam int KEY_W  = 8;                  // scalar width

    typedef logic [WORD_W-1:0] word_t;

    // field operation codes
    typedef enum logic [1:0] {
        GF_ADD = 2'b00,
        GF_SUB = 2'b01,
        GF_MUL = 2'b10,
        GF_DIV = 2'b11
    } gf_op_t;

endpackage

// File: gf_arith/gf_mod_mul.sv
module gf_mod_mul (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_start,
    input  ecc_pkg::word_t i_a,
    input  ecc_pkg::word_t i_b,
    input  ecc_pkg::word_t i_prime,
    output ecc_pkg::word_t o_product,
    output logic           o_done
);

    logic                                busy;
    logic [$clog2(ecc_pkg::WORD_W)-1:0]  bit_cnt;
    ecc_pkg::word_t                      acc;
    ecc_pkg::word_t                      b_sr;
    ecc_pkg::word_t                      dbl;
    ecc_pkg::word_t                      dbl_red;
    ecc_pkg::word_t                      sum;
    ecc_pkg::word_t                      acc_nxt;

    assign dbl     = {acc[ecc_pkg::WORD_W-2:0], 1'b0};     // acc < p < 2^31
    assign dbl_red = (dbl >= i_prime) ? dbl - i_prime : dbl;
    assign sum     = dbl_red + i_a;

    always_comb
    begin
        if (b_sr[ecc_pkg::WORD_W-1])
            acc_nxt = (sum >= i_prime) ? sum - i_prime : sum;
        else
            acc_nxt = dbl_red;
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            o_done  <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end
            else if (busy)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (&bit_cnt)                       // last multiplier bit
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // double and add from the msb down
    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            acc  <= '0;
            b_sr <= i_b;
        end
        else if (busy)
        begin
            acc  <= acc_nxt;
            b_sr <= {b_sr[ecc_pkg::WORD_W-2:0], 1'b0};
        end
    end

    assign o_product = acc;

endmodule

// File: gf_arith/gf_arith_unit.sv
module gf_arith_unit (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_start,
    input  ecc_pkg::gf_op_t i_op,
    input  ecc_pkg::word_t  i_opa,
    input  ecc_pkg::word_t  i_opb,
    input  ecc_pkg::word_t  i_prime,
    output ecc_pkg::word_t  o_result,
    output logic            o_done
);

    typedef enum logic [2:0] {S_IDLE, S_MUL, S_DNEXT, S_DMUL, S_DSQR} state_t;

    state_t         state;
    logic           quick_done;
    logic           mul_start;
    logic           mul_done;
    ecc_pkg::word_t mul_a;
    ecc_pkg::word_t mul_b;
    ecc_pkg::word_t product;
    ecc_pkg::word_t sum_raw;
    ecc_pkg::word_t diff_raw;
    ecc_pkg::word_t quick_res;
    ecc_pkg::word_t pow_acc;
    ecc_pkg::word_t pow_base;
    ecc_pkg::word_t exp_sr;

    assign sum_raw  = i_opa + i_opb;
    assign diff_raw = i_opa - i_opb;

    gf_mod_mul gf_mod_mul_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (mul_start),
        .i_a       (mul_a),
        .i_b       (mul_b),
        .i_prime   (i_prime),
        .o_product (product),
        .o_done    (mul_done)
    );

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state      <= S_IDLE;
            quick_done <= 1'b0;
            mul_start  <= 1'b0;
        end
        else
        begin
            quick_done <= 1'b0;
            mul_start  <= 1'b0;
            case (state)
                S_IDLE:
                    if (i_start)
                    begin
                        case (i_op)
                            ecc_pkg::GF_MUL:
                            begin
                                mul_start <= 1'b1;
                                state     <= S_MUL;
                            end
                            ecc_pkg::GF_DIV: state <= S_DNEXT;
                            default:         quick_done <= 1'b1;
                        endcase
                    end
                S_MUL:
                    if (mul_done)
                        state <= S_IDLE;
                S_DNEXT:
                begin
                    mul_start <= 1'b1;
                    if (exp_sr == '0)
                        state <= S_MUL;             // final a * b^(p-2)
                    else if (exp_sr[0])
                        state <= S_DMUL;
                    else
                        state <= S_DSQR;
                end
                default:
                    if (mul_done)
                        state <= S_DNEXT;
            endcase
        end
    end

    // exponent scanned lsb first
    always_ff @(posedge i_clk)
    begin
        case (state)
            S_IDLE:
                if (i_start)
                begin
                    if (i_op == ecc_pkg::GF_SUB)
                        quick_res <= (i_opa >= i_opb) ? diff_raw : diff_raw + i_prime;
                    else
                        quick_res <= (sum_raw >= i_prime) ? sum_raw - i_prime : sum_raw;
                    mul_a    <= i_opa;
                    mul_b    <= i_opb;
                    pow_acc  <= ecc_pkg::word_t'(1);
                    pow_base <= i_opb;
                    exp_sr   <= i_prime - ecc_pkg::word_t'(2);    // fermat
                end
            S_DNEXT:
            begin
                if (exp_sr == '0)
                begin
                    mul_a <= pow_acc;
                    mul_b <= i_opa;
                end
                else if (exp_sr[0])
                begin
                    mul_a <= pow_acc;
                    mul_b <= pow_base;
                end
                else
                begin
                    mul_a <= pow_base;
                    mul_b <= pow_base;
                end
            end
            S_DMUL:
                if (mul_done)
                begin
                    pow_acc   <= product;
                    exp_sr[0] <= 1'b0;
                end
            S_DSQR:
                if (mul_done)
                begin
                    pow_base <= product;
                    exp_sr   <= exp_sr >> 1;
                end
            default: ;
        endcase
    end

    assign o_done   = quick_done | ((state == S_MUL) && mul_done);
    assign o_result = (state == S_MUL) ? product : quick_res;

endmodule

// File: point_seq/point_sequencer.sv
module point_sequencer (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_load,
    input  logic            i_double,
    input  logic            i_add,
    input  ecc_pkg::word_t  i_px,
    input  ecc_pkg::word_t  i_py,
    input  ecc_pkg::word_t  i_a,
    input  ecc_pkg::word_t  i_prime,
    input  logic            i_op_done,
    input  ecc_pkg::word_t  i_result,
    output logic            o_op_start,
    output ecc_pkg::gf_op_t o_op,
    output ecc_pkg::word_t  o_opa,
    output ecc_pkg::word_t  o_opb,
    output ecc_pkg::word_t  o_prime,
    output logic            o_step_done,
    output ecc_pkg::word_t  o_qx,
    output ecc_pkg::word_t  o_qy
);

    typedef enum logic [2:0] {R_QX, R_QY, R_PX, R_PY, R_A, R_T0, R_T1} reg_sel_t;

    typedef struct packed {
        ecc_pkg::gf_op_t op;
        reg_sel_t        src_a;
        reg_sel_t        src_b;
        reg_sel_t        dst;
        logic            last;
    } uop_t;

    logic           running;
    logic           is_add;
    logic [3:0]     step;
    uop_t           uop;
    ecc_pkg::word_t px;
    ecc_pkg::word_t py;
    ecc_pkg::word_t qx;
    ecc_pkg::word_t qy;
    ecc_pkg::word_t a_reg;
    ecc_pkg::word_t prime;
    ecc_pkg::word_t t0;
    ecc_pkg::word_t t1;

    function automatic ecc_pkg::word_t pick(reg_sel_t sel);
        ecc_pkg::word_t val;
        case (sel)
            R_QX:    val = qx;
            R_QY:    val = qy;
            R_PX:    val = px;
            R_PY:    val = py;
            R_A:     val = a_reg;
            R_T0:    val = t0;
            default: val = t1;
        endcase
        return val;
    endfunction

    always_comb
    begin
        uop = '{ecc_pkg::GF_ADD, R_T0, R_T0, R_T0, 1'b0};
        if (!is_add)
        begin
            case (step)
                4'd0:  uop = '{ecc_pkg::GF_MUL, R_QX, R_QX, R_T0, 1'b0};   // x^2
                4'd1:  uop = '{ecc_pkg::GF_ADD, R_T0, R_T0, R_T1, 1'b0};
                4'd2:  uop = '{ecc_pkg::GF_ADD, R_T0, R_T1, R_T0, 1'b0};   // 3x^2
                4'd3:  uop = '{ecc_pkg::GF_ADD, R_T0, R_A,  R_T0, 1'b0};
                4'd4:  uop = '{ecc_pkg::GF_ADD, R_QY, R_QY, R_T1, 1'b0};   // 2y
                4'd5:  uop = '{ecc_pkg::GF_DIV, R_T0, R_T1, R_T0, 1'b0};   // lambda
                4'd6:  uop = '{ecc_pkg::GF_MUL, R_T0, R_T0, R_T1, 1'b0};
                4'd7:  uop = '{ecc_pkg::GF_SUB, R_T1, R_QX, R_T1, 1'b0};
                4'd8:  uop = '{ecc_pkg::GF_SUB, R_T1, R_QX, R_T1, 1'b0};   // x3
                4'd9:  uop = '{ecc_pkg::GF_SUB, R_QX, R_T1, R_QX, 1'b0};
                4'd10: uop = '{ecc_pkg::GF_MUL, R_T0, R_QX, R_T0, 1'b0};
                4'd11: uop = '{ecc_pkg::GF_SUB, R_T0, R_QY, R_QY, 1'b1};   // y3
                default: ;
            endcase
        end
        else
        begin
            case (step)
                4'd0:  uop = '{ecc_pkg::GF_SUB, R_PY, R_QY, R_T0, 1'b0};
                4'd1:  uop = '{ecc_pkg::GF_SUB, R_PX, R_QX, R_T1, 1'b0};
                4'd2:  uop = '{ecc_pkg::GF_DIV, R_T0, R_T1, R_T0, 1'b0};   // lambda
                4'd3:  uop = '{ecc_pkg::GF_MUL, R_T0, R_T0, R_T1, 1'b0};
                4'd4:  uop = '{ecc_pkg::GF_SUB, R_T1, R_QX, R_T1, 1'b0};
                4'd5:  uop = '{ecc_pkg::GF_SUB, R_T1, R_PX, R_T1, 1'b0};   // x3
                4'd6:  uop = '{ecc_pkg::GF_SUB, R_QX, R_T1, R_QX, 1'b0};
                4'd7:  uop = '{ecc_pkg::GF_MUL, R_T0, R_QX, R_T0, 1'b0};
                4'd8:  uop = '{ecc_pkg::GF_SUB, R_T0, R_QY, R_QY, 1'b1};   // y3
                default: ;
            endcase
        end
    end

    always_comb
    begin
        o_opa = pick(uop.src_a);
        o_opb = pick(uop.src_b);
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            running     <= 1'b0;
            is_add      <= 1'b0;
            step        <= '0;
            o_op_start  <= 1'b0;
            o_step_done <= 1'b0;
        end
        else
        begin
            o_op_start  <= 1'b0;
            o_step_done <= 1'b0;
            if (!running)
            begin
                if (i_double || i_add)
                begin
                    running    <= 1'b1;
                    is_add     <= i_add;
                    step       <= '0;
                    o_op_start <= 1'b1;
                end
            end
            else if (i_op_done)
            begin
                if (uop.last)
                begin
                    running     <= 1'b0;
                    o_step_done <= 1'b1;
                end
                else
                begin
                    step       <= step + 1'b1;
                    o_op_start <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            px    <= i_px;
            py    <= i_py;
            qx    <= i_px;                      // Q starts at P
            qy    <= i_py;
            a_reg <= i_a;
            prime <= i_prime;
        end
        else if (running && i_op_done)
        begin
            case (uop.dst)
                R_QX:    qx <= i_result;
                R_QY:    qy <= i_result;
                R_T0:    t0 <= i_result;
                default: t1 <= i_result;
            endcase
            if (uop.last)
                qx <= t1;                       // x3 waits in t1
        end
    end

    assign o_op    = uop.op;
    assign o_prime = prime;
    assign o_qx    = qx;
    assign o_qy    = qy;

endmodule

// File: hdl/scalar_ctrl.sv
module scalar_ctrl (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_start,
    input  logic [ecc_pkg::KEY_W-1:0] i_key,
    input  logic                      i_step_done,
    output logic                      o_load,
    output logic                      o_double,
    output logic                      o_add,
    output logic                      o_busy,
    output logic                      o_done
);

    typedef enum logic [1:0] {S_IDLE, S_DBL, S_ADD} state_t;
    typedef logic [$clog2(ecc_pkg::KEY_W)-1:0] cnt_t;

    state_t                    state;
    logic [ecc_pkg::KEY_W-1:0] key_sr;
    cnt_t                      bits_left;
    logic                      take_add;
    logic                      advance;

    assign o_load   = i_start && (state == S_IDLE);
    assign o_busy   = (state != S_IDLE);
    assign take_add = i_step_done && (state == S_DBL) && key_sr[ecc_pkg::KEY_W-1];
    assign advance  = i_step_done && (state != S_IDLE) && !take_add;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state     <= S_IDLE;
            key_sr    <= '0;
            bits_left <= '0;
            o_double  <= 1'b0;
            o_add     <= 1'b0;
            o_done    <= 1'b0;
        end
        else
        begin
            o_double <= 1'b0;
            o_add    <= 1'b0;
            o_done   <= 1'b0;
            if (o_load)
            begin
                key_sr    <= i_key << 1;        // top bit consumed by Q = P
                bits_left <= cnt_t'(ecc_pkg::KEY_W - 1);
                o_double  <= 1'b1;
                state     <= S_DBL;
            end
            else if (take_add)
            begin
                o_add <= 1'b1;
                state <= S_ADD;
            end
            else if (advance)
            begin
                key_sr    <= key_sr << 1;
                bits_left <= bits_left - 1'b1;
                if (bits_left == 1)
                begin
                    o_done <= 1'b1;
                    state  <= S_IDLE;
                end
                else
                begin
                    o_double <= 1'b1;
                    state    <= S_DBL;
                end
            end
        end
    end

endmodule

// File: hdl/ecc_scalar_top.sv
module ecc_scalar_top (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_start,
    input  logic [ecc_pkg::KEY_W-1:0] i_key,
    input  ecc_pkg::word_t            i_px,
    input  ecc_pkg::word_t            i_py,
    input  ecc_pkg::word_t            i_a,
    input  ecc_pkg::word_t            i_prime,
    output ecc_pkg::word_t            o_qx,
    output ecc_pkg::word_t            o_qy,
    output logic                      o_busy,
    output logic                      o_done
);

    logic            load;
    logic            dbl;
    logic            add;
    logic            step_done;
    logic            op_start;
    logic            op_done;
    ecc_pkg::gf_op_t op;
    ecc_pkg::word_t  opa;
    ecc_pkg::word_t  opb;
    ecc_pkg::word_t  prime;
    ecc_pkg::word_t  result;

    scalar_ctrl scalar_ctrl_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_key       (i_key),
        .i_step_done (step_done),
        .o_load      (load),
        .o_double    (dbl),
        .o_add       (add),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    point_sequencer point_sequencer_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_load      (load),
        .i_double    (dbl),
        .i_add       (add),
        .i_px        (i_px),
        .i_py        (i_py),
        .i_a         (i_a),
        .i_prime     (i_prime),
        .i_op_done   (op_done),
        .i_result    (result),
        .o_op_start  (op_start),
        .o_op        (op),
        .o_opa       (opa),
        .o_opb       (opb),
        .o_prime     (prime),
        .o_step_done (step_done),
        .o_qx        (o_qx),
        .o_qy        (o_qy)
    );

    gf_arith_unit gf_arith_unit_i (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (op_start),
        .i_op     (op),
        .i_opa    (opa),
        .i_opb    (opb),
        .i_prime  (prime),
        .o_result (result),
        .o_done   (op_done)
    );

endmodule

// File: test/ecc_scalar_tb.sv
module ecc_scalar_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam longint PRIME          = 64'd2147483647;
    localparam int     NUM_RANDOM     = 6;
    localparam int     NUM_RUNS       = NUM_RANDOM + 3;    // random, 8'h80, 8'hff, busy
    localparam int     STEP_CYCLES    = 2400;
    localparam int     TIMEOUT_CYCLES = NUM_RUNS * 16 * STEP_CYCLES;

    logic                      i_clk;
    logic                      i_reset;
    logic                      i_start;
    logic [ecc_pkg::KEY_W-1:0] i_key;
    ecc_pkg::word_t            i_px;
    ecc_pkg::word_t            i_py;
    ecc_pkg::word_t            i_a;
    ecc_pkg::word_t            i_prime;
    ecc_pkg::word_t            o_qx;
    ecc_pkg::word_t            o_qy;
    logic                      o_busy;
    logic                      o_done;

    integer seed;
    int     err_cnt   = 0;
    int     check_cnt = 0;
    int     done_cnt  = 0;
    int     cycle_cnt = 0;
    longint base_x;
    longint base_y;
    longint curve_a;

    ecc_scalar_top ecc_scalar_top_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (i_start),
        .i_key   (i_key),
        .i_px    (i_px),
        .i_py    (i_py),
        .i_a     (i_a),
        .i_prime (i_prime),
        .o_qx    (o_qx),
        .o_qy    (o_qy),
        .o_busy  (o_busy),
        .o_done  (o_done)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
            #20 i_clk = ~i_clk;
    end

    initial
    begin
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge i_clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout after %0d cycles, o_done never came", cycle_cnt);
        $display("TESTS FAILED");
        $finish;
    end

    always @(negedge i_clk)
    begin
        if (o_done)
            done_cnt = done_cnt + 1;
    end

    done_single_cycle : assert property (
        @(posedge i_clk) disable iff (i_reset) o_done |=> !o_done
    )
    else
    begin
        err_cnt++;
        $display("o_done stayed high longer than one cycle at %0t", $time);
    end

    busy_falls_with_done : assert property (
        @(posedge i_clk) disable iff (i_reset) o_done |-> (!o_busy && $past(o_busy))
    )
    else
    begin
        err_cnt++;
        $display("o_busy did not fall in the o_done cycle at %0t", $time);
    end

    busy_after_start : assert property (
        @(posedge i_clk) disable iff (i_reset) (i_start && !o_busy) |=> o_busy
    )
    else
    begin
        err_cnt++;
        $display("o_busy did not rise after an accepted start at %0t", $time);
    end

    function automatic longint add_mod(longint x, longint y);
        return (x + y) % PRIME;
    endfunction

    function automatic longint sub_mod(longint x, longint y);
        return (x - y + PRIME) % PRIME;
    endfunction

    function automatic longint mul_mod(longint x, longint y);
        return (x * y) % PRIME;
    endfunction

    // extended euclid with zero mapped to zero
    function automatic longint invert(longint v);
        longint t;
        longint new_t;
        longint r;
        longint new_r;
        longint q;
        longint tmp;
        t     = 0;
        new_t = 1;
        r     = PRIME;
        new_r = v;
        while (new_r != 0)
        begin
            q     = r / new_r;
            tmp   = t - q * new_t;
            t     = new_t;
            new_t = tmp;
            tmp   = r - q * new_r;
            r     = new_r;
            new_r = tmp;
        end
        if (t < 0)
            t = t + PRIME;
        return t;
    endfunction

    task automatic point_double(input longint x, input longint y,
                                output longint x3, output longint y3, output bit bad);
        longint lam;
        bad = (y == 0);
        lam = mul_mod(add_mod(mul_mod(3, mul_mod(x, x)), curve_a), invert(add_mod(y, y)));
        x3  = sub_mod(mul_mod(lam, lam), add_mod(x, x));
        y3  = sub_mod(mul_mod(lam, sub_mod(x, x3)), y);
    endtask

    task automatic point_add(input longint x1, input longint y1, input longint x2,
                             input longint y2, output longint x3, output longint y3,
                             output bit bad);
        longint lam;
        bad = (x1 == x2);                       // Q = P or Q = -P
        lam = mul_mod(sub_mod(y2, y1), invert(sub_mod(x2, x1)));
        x3  = sub_mod(sub_mod(mul_mod(lam, lam), x1), x2);
        y3  = sub_mod(mul_mod(lam, sub_mod(x1, x3)), y1);
    endtask

    // left to right double and add
    task automatic kp_reference(input logic [ecc_pkg::KEY_W-1:0] key,
                                output ecc_pkg::word_t rx, output ecc_pkg::word_t ry,
                                output bit bad);
        longint qx;
        longint qy;
        longint nx;
        longint ny;
        bit     step_bad;
        int     i;
        bad = 1'b0;
        qx  = base_x;
        qy  = base_y;
        for (i = ecc_pkg::KEY_W - 2; i >= 0; i--)
        begin
            point_double(qx, qy, nx, ny, step_bad);
            bad = bad | step_bad;
            qx  = nx;
            qy  = ny;
            if (key[i])
            begin
                point_add(qx, qy, base_x, base_y, nx, ny, step_bad);
                bad = bad | step_bad;
                qx  = nx;
                qy  = ny;
            end
        end
        rx = ecc_pkg::word_t'(qx);
        ry = ecc_pkg::word_t'(qy);
    endtask

    task automatic draw_element(output longint v);
        integer rnd;
        rnd = $random(seed);
        v   = longint'($unsigned(rnd)) % PRIME;
    endtask

    // fixed keys must stay clear of zero divisors too
    task automatic pick_curve();
        ecc_pkg::word_t rx;
        ecc_pkg::word_t ry;
        bit             bad_lo;
        bit             bad_hi;
        do
        begin
            draw_element(base_x);
            draw_element(base_y);
            draw_element(curve_a);
            kp_reference(8'h80, rx, ry, bad_lo);
            kp_reference(8'hff, rx, ry, bad_hi);
        end
        while (bad_lo || bad_hi);
    endtask

    task automatic check_word(input string sig, input ecc_pkg::word_t got,
                              input ecc_pkg::word_t exp);
        check_cnt++;
        assert (got == exp)
        else
        begin
            err_cnt++;
            $display("Fail %s: got %08h, expected %08h", sig, got, exp);
        end
    endtask

    task automatic pulse_start(input logic [ecc_pkg::KEY_W-1:0] key);
        @(posedge i_clk);
        #2;
        i_key   = key;
        i_start = 1'b1;
        @(posedge i_clk);
        #2;
        i_start = 1'b0;
    endtask

    task automatic finish_and_check(input ecc_pkg::word_t ex, input ecc_pkg::word_t ey);
        @(negedge i_clk);
        while (!o_done)
            @(negedge i_clk);
        check_word("o_qx", o_qx, ex);
        check_word("o_qy", o_qy, ey);
        repeat (3) @(negedge i_clk);
        check_word("o_qx", o_qx, ex);           // held after done
        check_word("o_qy", o_qy, ey);
    endtask

    task automatic run_and_check(input logic [ecc_pkg::KEY_W-1:0] key,
                                 input ecc_pkg::word_t ex, input ecc_pkg::word_t ey);
        pulse_start(key);
        finish_and_check(ex, ey);
    endtask

    task automatic draw_key(output logic [ecc_pkg::KEY_W-1:0] key,
                            output ecc_pkg::word_t ex, output ecc_pkg::word_t ey);
        integer rnd;
        bit     bad;
        do
        begin
            rnd = $random(seed);
            key = rnd[ecc_pkg::KEY_W-1:0] | 8'h80;     // top bit set
            kp_reference(key, ex, ey, bad);
        end
        while (bad);
    endtask

    initial
    begin
        logic [ecc_pkg::KEY_W-1:0] key;
        ecc_pkg::word_t            ex;
        ecc_pkg::word_t            ey;
        bit                        bad;
        int                        run;
        seed    = 32'h7d3c_f644;
        i_reset = 1'b1;
        i_start = 1'b0;
        i_key   = '0;
        i_prime = ecc_pkg::word_t'(PRIME);
        pick_curve();
        i_px = ecc_pkg::word_t'(base_x);
        i_py = ecc_pkg::word_t'(base_y);
        i_a  = ecc_pkg::word_t'(curve_a);
        repeat (8) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
        @(negedge i_clk);
        check_word("o_busy", ecc_pkg::word_t'(o_busy), '0);
        check_word("o_done", ecc_pkg::word_t'(o_done), '0);

        for (run = 0; run < NUM_RANDOM; run++)
        begin
            draw_key(key, ex, ey);
            run_and_check(key, ex, ey);
        end

        kp_reference(8'h80, ex, ey, bad);       // doublings only
        run_and_check(8'h80, ex, ey);
        kp_reference(8'hff, ex, ey, bad);
        run_and_check(8'hff, ex, ey);

        // second start lands mid-run and must be dropped
        draw_key(key, ex, ey);
        pulse_start(key);
        repeat (20) @(negedge i_clk);
        check_word("o_busy", ecc_pkg::word_t'(o_busy), ecc_pkg::word_t'(1));
        pulse_start(key ^ 8'h7f);
        finish_and_check(ex, ey);

        repeat (4) @(negedge i_clk);
        check_cnt++;
        assert (done_cnt == NUM_RUNS)
        else
        begin
            err_cnt++;
            $display("saw %0d o_done pulses for %0d accepted starts", done_cnt, NUM_RUNS);
        end
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: sim.f
common/ecc_pkg.sv
gf_arith/gf_mod_mul.sv
gf_arith/gf_arith_unit.sv
point_seq/point_sequencer.sv
hdl/scalar_ctrl.sv
hdl/ecc_scalar_top.sv
test/ecc_scalar_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ecc_scalar_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
